//--- rtl/soc_pkg.sv
`default_nettype none

package soc_pkg;

  typedef logic [31:0] word_t;  // one bus data word

  // single access from the bus master
  typedef struct packed {
    logic [31:0] addr;   // byte address
    word_t       wdata;  // write data
    logic [3:0]  wmask;  // byte lane write enables
    logic        rstrb;  // read strobe, one cycle
  } bus_req_t;

  // one-hot unit select
  typedef struct packed {
    logic ram;   // default target
    logic sqrt;  // square root unit
    logic mult;  // multiplier unit
    logic div;   // divider unit
  } periph_cs_t;

  // region codes, matched against addr[31:16]
  localparam logic [15:0] REGION_SQRT = 16'h0041;
  localparam logic [15:0] REGION_MULT = 16'h0042;
  localparam logic [15:0] REGION_DIV  = 16'h0043;

  // coprocessor register map, byte offsets in addr[4:0]
  localparam logic [4:0] REG_OP_A   = 5'h00;  // first operand
  localparam logic [4:0] REG_OP_B   = 5'h04;  // second operand
  localparam logic [4:0] REG_START  = 5'h08;  // any write kicks off
  localparam logic [4:0] REG_STATUS = 5'h0C;  // status_t, zero-extended
  localparam logic [4:0] REG_RESULT = 5'h10;  // result word

  // coprocessor status, busy in bit 0
  typedef struct packed {
    logic done;  // bit 1, set at completion
    logic busy;  // bit 0, iterating
  } status_t;

endpackage

`default_nettype wire

//--- rtl/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  input  logic                clk,
  input  logic                arst_n,
  input  soc_pkg::bus_req_t   req,         // access from master
  output soc_pkg::periph_cs_t cs,          // one-hot unit select
  input  soc_pkg::word_t      ram_rdata,   // read data per unit
  input  soc_pkg::word_t      sqrt_rdata,
  input  soc_pkg::word_t      mult_rdata,
  input  soc_pkg::word_t      div_rdata,
  output soc_pkg::word_t      rdata        // back to master
);

  soc_pkg::periph_cs_t rd_sel;  // unit of the last read strobe

  // region decode, everything unknown lands in ram
  always_comb begin
    cs = '0;
    case (req.addr[31:16])
      soc_pkg::REGION_SQRT: begin
        cs.sqrt = 1'b1;
      end
      soc_pkg::REGION_MULT: begin
        cs.mult = 1'b1;
      end
      soc_pkg::REGION_DIV: begin
        cs.div = 1'b1;
      end
      default: begin
        cs.ram = 1'b1;  // ram and all unused regions
      end
    endcase
  end

  // the units answer one cycle after the strobe, so the select
  // has to be remembered until the data comes back
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_sel <= '{ram: 1'b1, default: 1'b0};  // ram after reset
    end else if (req.rstrb) begin
      rd_sel <= cs;  // held until next strobe
    end
  end

  // return data mux
  always_comb begin
    case (1'b1)
      rd_sel.sqrt: begin
        rdata = sqrt_rdata;
      end
      rd_sel.mult: begin
        rdata = mult_rdata;
      end
      rd_sel.div: begin
        rdata = div_rdata;
      end
      default: begin
        rdata = ram_rdata;  // ram is the fallback
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/bram.sv
`timescale 1ns/1ps
`default_nettype none

module bram #(
  parameter int RAM_ADDR_W = 8  // word address bits
) (
  input  logic              clk,
  input  soc_pkg::bus_req_t req,    // shared bus access
  input  logic              cs,     // ram selected
  output soc_pkg::word_t    rdata   // registered read word
);

  localparam int DEPTH = 2 ** RAM_ADDR_W;  // words

  soc_pkg::word_t        mem [DEPTH];     // storage, no reset
  logic [RAM_ADDR_W-1:0] idx;             // word index
  soc_pkg::word_t        rdata_q = '0;    // zero until first read

  // upper address bits dropped, ram repeats across the map
  assign idx = req.addr[RAM_ADDR_W+1:2];

  // byte lane writes
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (cs && req.wmask[lane]) begin
        mem[idx][lane*8 +: 8] <= req.wdata[lane*8 +: 8];  // only masked lanes
      end
    end
  end

  // read port, loads on a selected strobe only
  always_ff @(posedge clk) begin
    if (cs && req.rstrb) begin
      rdata_q <= mem[idx];  // old word on same-cycle write
    end
  end

  assign rdata = rdata_q;  // stays until next read

endmodule

`default_nettype wire

//--- rtl/periph_mult.sv
`timescale 1ns/1ps
`default_nettype none

module periph_mult #(
  parameter int OPW = 16  // operand width
) (
  input  logic              clk,
  input  logic              arst_n,
  input  soc_pkg::bus_req_t req,    // shared bus access
  input  logic              cs,     // unit selected
  output soc_pkg::word_t    rdata   // registered read word
);

  localparam int CNT_W = $clog2(OPW);

  logic [4:0]       offs;     // register offset
  logic             wr;
  logic             rd;
  logic             start;    // accepted start
  logic             last;     // final iteration
  logic [OPW-1:0]   op_a;
  logic [OPW-1:0]   op_b;
  logic [2*OPW-1:0] mcand;    // multiplicand, shifts left
  logic [OPW-1:0]   mplier;   // multiplier, lsb consumed first
  logic [2*OPW-1:0] acc;      // partial product
  logic [2*OPW-1:0] acc_nxt;
  logic [CNT_W-1:0] cnt;      // iteration count
  soc_pkg::status_t status;
  soc_pkg::word_t   result;

  assign offs    = req.addr[4:0];
  assign wr      = cs && (req.wmask != 4'b0000);
  assign rd      = cs && req.rstrb;
  assign start   = wr && (offs == soc_pkg::REG_START) && !status.busy;  // ignored if busy
  assign last    = (cnt == CNT_W'(OPW - 1));
  assign acc_nxt = mplier[0] ? acc + mcand : acc;  // add when bit set

  // status, counter, result
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      status <= '0;
      cnt    <= '0;
      result <= '0;
    end else if (start) begin
      status.busy <= 1'b1;
      status.done <= 1'b0;
      cnt         <= '0;
    end else if (status.busy) begin
      cnt <= cnt + 1'b1;
      if (last) begin
        status.busy <= 1'b0;
        status.done <= 1'b1;
        result      <= 32'(acc_nxt);  // full product
      end
    end
  end

  // operands, datapath, read port
  always_ff @(posedge clk) begin
    if (wr && (offs == soc_pkg::REG_OP_A)) begin
      op_a <= req.wdata[OPW-1:0];
    end
    if (wr && (offs == soc_pkg::REG_OP_B)) begin
      op_b <= req.wdata[OPW-1:0];
    end
    if (start) begin
      mcand  <= {{OPW{1'b0}}, op_a};  // working copy, op regs free again
      mplier <= op_b;
      acc    <= '0;
    end else if (status.busy) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      acc    <= acc_nxt;
    end
    if (rd) begin
      case (offs)
        soc_pkg::REG_STATUS: rdata <= {30'd0, status};
        soc_pkg::REG_RESULT: rdata <= result;
        default:             rdata <= '0;  // nothing else readable
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/periph_div.sv
`timescale 1ns/1ps
`default_nettype none

module periph_div #(
  parameter int OPW = 16  // operand width
) (
  input  logic              clk,
  input  logic              arst_n,
  input  soc_pkg::bus_req_t req,    // shared bus access
  input  logic              cs,     // unit selected
  output soc_pkg::word_t    rdata   // registered read word
);

  localparam int CNT_W = $clog2(OPW);

  logic [4:0]       offs;     // register offset
  logic             wr;
  logic             rd;
  logic             start;    // accepted start
  logic             last;     // final iteration
  logic [OPW-1:0]   op_a;     // dividend
  logic [OPW-1:0]   op_b;     // divisor
  logic [OPW-1:0]   dvsr;     // divisor copy
  logic [OPW-1:0]   quo;      // dividend in, quotient out
  logic [OPW-1:0]   rem;      // partial remainder
  logic [OPW:0]     shifted;  // remainder with next dividend bit
  logic [OPW:0]     diff;     // trial subtraction
  logic             fits;     // divisor goes in
  logic [OPW-1:0]   rem_nxt;
  logic [OPW-1:0]   quo_nxt;
  logic [CNT_W-1:0] cnt;      // iteration count
  soc_pkg::status_t status;
  soc_pkg::word_t   result;

  assign offs  = req.addr[4:0];
  assign wr    = cs && (req.wmask != 4'b0000);
  assign rd    = cs && req.rstrb;
  assign start = wr && (offs == soc_pkg::REG_START) && !status.busy;
  assign last  = (cnt == CNT_W'(OPW - 1));

  // one restoring step per cycle
  // a zero divisor always fits, so the quotient goes all ones
  // and the dividend bits pile up in the remainder
  assign shifted = {rem, quo[OPW-1]};
  assign diff    = shifted - {1'b0, dvsr};
  assign fits    = (shifted >= {1'b0, dvsr});
  assign rem_nxt = fits ? diff[OPW-1:0] : shifted[OPW-1:0];  // keep or restore
  assign quo_nxt = {quo[OPW-2:0], fits};  // quotient bit enters at lsb

  // status, counter, result
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      status <= '0;
      cnt    <= '0;
      result <= '0;
    end else if (start) begin
      status.busy <= 1'b1;
      status.done <= 1'b0;
      cnt         <= '0;
    end else if (status.busy) begin
      cnt <= cnt + 1'b1;
      if (last) begin
        status.busy <= 1'b0;
        status.done <= 1'b1;
        result      <= {16'(rem_nxt), 16'(quo_nxt)};  // rem high, quo low
      end
    end
  end

  // operands, datapath, read port
  always_ff @(posedge clk) begin
    if (wr && (offs == soc_pkg::REG_OP_A)) begin
      op_a <= req.wdata[OPW-1:0];
    end
    if (wr && (offs == soc_pkg::REG_OP_B)) begin
      op_b <= req.wdata[OPW-1:0];
    end
    if (start) begin
      quo  <= op_a;
      dvsr <= op_b;
      rem  <= '0;
    end else if (status.busy) begin
      quo <= quo_nxt;
      rem <= rem_nxt;
    end
    if (rd) begin
      case (offs)
        soc_pkg::REG_STATUS: rdata <= {30'd0, status};
        soc_pkg::REG_RESULT: rdata <= result;
        default:             rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/periph_sqrt.sv
`timescale 1ns/1ps
`default_nettype none

module periph_sqrt #(
  parameter int OPW = 16  // radicand width, even
) (
  input  logic              clk,
  input  logic              arst_n,
  input  soc_pkg::bus_req_t req,    // shared bus access
  input  logic              cs,     // unit selected
  output soc_pkg::word_t    rdata   // registered read word
);

  localparam int HW    = OPW / 2;      // root width, also iterations
  localparam int RW    = HW + 4;       // signed remainder with headroom
  localparam int CNT_W = $clog2(OPW);

  logic [4:0]       offs;      // register offset
  logic             wr;
  logic             rd;
  logic             start;     // accepted start
  logic             last;      // final iteration
  logic [OPW-1:0]   op_a;      // radicand, op_b writes are dropped
  logic [OPW-1:0]   rad;       // radicand, two bits per step from top
  logic [HW-1:0]    root;
  logic [RW-1:0]    prem;      // partial remainder, two's complement
  logic [RW-1:0]    prem_sh;   // remainder with next bit pair
  logic [RW-1:0]    prem_nxt;
  logic [HW-1:0]    root_nxt;
  logic [RW-1:0]    rem_fix;   // final remainder, made non-negative
  logic [CNT_W-1:0] cnt;       // iteration count
  soc_pkg::status_t status;
  soc_pkg::word_t   result;

  assign offs  = req.addr[4:0];
  assign wr    = cs && (req.wmask != 4'b0000);
  assign rd    = cs && req.rstrb;
  assign start = wr && (offs == soc_pkg::REG_START) && !status.busy;
  assign last  = (cnt == CNT_W'(HW - 1));

  // non-restoring step: subtract 4q+1 when the remainder is
  // non-negative, add back 4q+3 when it went negative
  assign prem_sh  = {prem[RW-3:0], rad[OPW-1 -: 2]};
  assign prem_nxt = prem[RW-1] ? prem_sh + {2'b00, root, 2'b11}
                               : prem_sh - {2'b00, root, 2'b01};
  assign root_nxt = HW'({root, ~prem_nxt[RW-1]});  // 1 when still >= 0
  // one correction after the last step if still negative
  assign rem_fix  = prem_nxt[RW-1] ? prem_nxt + {3'b000, root_nxt, 1'b1} : prem_nxt;

  // status, counter, result
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      status <= '0;
      cnt    <= '0;
      result <= '0;
    end else if (start) begin
      status.busy <= 1'b1;
      status.done <= 1'b0;
      cnt         <= '0;
    end else if (status.busy) begin
      cnt <= cnt + 1'b1;
      if (last) begin
        status.busy <= 1'b0;
        status.done <= 1'b1;
        result      <= {16'(rem_fix), 16'(root_nxt)};  // rem high, root low
      end
    end
  end

  // operand, datapath, read port
  always_ff @(posedge clk) begin
    if (wr && (offs == soc_pkg::REG_OP_A)) begin
      op_a <= req.wdata[OPW-1:0];
    end
    if (start) begin
      rad  <= op_a;
      root <= '0;
      prem <= '0;
    end else if (status.busy) begin
      rad  <= rad << 2;  // next pair to the top
      root <= root_nxt;
      prem <= prem_nxt;
    end
    if (rd) begin
      case (offs)
        soc_pkg::REG_STATUS: rdata <= {30'd0, status};
        soc_pkg::REG_RESULT: rdata <= result;
        default:             rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/periph_soc.sv
`timescale 1ns/1ps
`default_nettype none

module periph_soc #(
  parameter int RAM_ADDR_W = 8,   // ram word address bits
  parameter int OPW        = 16   // coprocessor operand width, even, max 16
) (
  input  logic              clk,
  input  logic              arst_n,
  input  soc_pkg::bus_req_t req,    // access from the master
  output soc_pkg::word_t    rdata   // read data, one cycle after rstrb
);

  soc_pkg::periph_cs_t cs;          // decoded unit select
  soc_pkg::word_t      ram_rdata;   // per unit read words
  soc_pkg::word_t      sqrt_rdata;
  soc_pkg::word_t      mult_rdata;
  soc_pkg::word_t      div_rdata;

  // address decode and read return
  bus_decoder i_bus_decoder (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .cs         (cs),
    .ram_rdata  (ram_rdata),
    .sqrt_rdata (sqrt_rdata),
    .mult_rdata (mult_rdata),
    .div_rdata  (div_rdata),
    .rdata      (rdata)
  );

  // block ram, default target
  bram #(
    .RAM_ADDR_W (RAM_ADDR_W)
  ) i_bram (
    .clk   (clk),
    .req   (req),
    .cs    (cs.ram),
    .rdata (ram_rdata)
  );

  // region 0x0042
  periph_mult #(
    .OPW (OPW)
  ) i_periph_mult (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .cs     (cs.mult),
    .rdata  (mult_rdata)
  );

  // region 0x0043
  periph_div #(
    .OPW (OPW)
  ) i_periph_div (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .cs     (cs.div),
    .rdata  (div_rdata)
  );

  // region 0x0041
  periph_sqrt #(
    .OPW (OPW)
  ) i_periph_sqrt (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .cs     (cs.sqrt),
    .rdata  (sqrt_rdata)
  );

endmodule

`default_nettype wire

//--- verif/tb_periph_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_periph_soc;

  localparam int RAM_ADDR_W = 8;
  localparam int OPW        = 16;
  localparam int POLL_LIMIT = 64;  // status reads before giving up

  logic              clk;
  logic              arst_n;
  soc_pkg::bus_req_t req;
  soc_pkg::word_t    rdata;
  soc_pkg::word_t    rd_held;      // rdata seen during the strobe cycle
  logic [31:0]       lfsr_state;
  string             test_name;

  periph_soc #(
    .RAM_ADDR_W (RAM_ADDR_W),
    .OPW        (OPW)
  ) i_periph_soc (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .rdata  (rdata)
  );

  always #4 clk = ~clk;  // 8 ns period

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};  // one step per bit
    end
  endtask

  function automatic logic [31:0] reg_addr(input logic [15:0] region, input logic [4:0] offs);
    return {region, 11'd0, offs};
  endfunction

  // expected results by plain arithmetic
  function automatic soc_pkg::word_t exp_product(input logic [OPW-1:0] a,
                                                 input logic [OPW-1:0] b);
    return 32'(a) * 32'(b);
  endfunction

  function automatic soc_pkg::word_t exp_quot_rem(input logic [OPW-1:0] a,
                                                  input logic [OPW-1:0] b);
    logic [OPW-1:0] q;
    logic [OPW-1:0] r;
    if (b == '0) begin
      q = '1;  // divide by zero rule
      r = a;
    end else begin
      q = a / b;
      r = a % b;
    end
    return {16'(r), 16'(q)};
  endfunction

  function automatic soc_pkg::word_t exp_root(input logic [OPW-1:0] a);
    int unsigned val;
    int unsigned root;
    val  = 32'(a);
    root = 0;
    while ((root + 1) * (root + 1) <= val) begin
      root++;  // floor root by search
    end
    return {16'(val - root * root), 16'(root)};
  endfunction

  task automatic stop_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string what, input soc_pkg::word_t exp,
                            input soc_pkg::word_t act);
    if (act !== exp) begin
      $display("[ERROR] %s, %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
      stop_run();
    end
  endtask

  task automatic check_status(input string what, input soc_pkg::status_t exp,
                              input soc_pkg::status_t act);
    if (act !== exp) begin
      $display("[ERROR] %s, %s: expected %b, actual %b", test_name, what, exp, act);
      stop_run();
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input soc_pkg::word_t data,
                           input logic [3:0] mask);
    @(posedge clk);
    req <= '{addr: addr, wdata: data, wmask: mask, rstrb: 1'b0};
    @(posedge clk);  // write lands here
    req <= '{addr: addr, wdata: '0, wmask: 4'h0, rstrb: 1'b0};
  endtask

  task automatic bus_read(input logic [31:0] addr, output soc_pkg::word_t data);
    @(posedge clk);
    req <= '{addr: addr, wdata: '0, wmask: 4'h0, rstrb: 1'b1};
    @(negedge clk);
    rd_held = rdata;  // previous word still on the bus
    @(posedge clk);
    req <= '{addr: addr, wdata: '0, wmask: 4'h0, rstrb: 1'b0};
    @(negedge clk);
    data = rdata;     // one cycle after the strobe
  endtask

  task automatic wait_done(input logic [15:0] region);
    soc_pkg::word_t st;
    int             polls;
    st    = '0;
    polls = 0;
    while (st[1] !== 1'b1 && polls < POLL_LIMIT) begin
      bus_read(reg_addr(region, soc_pkg::REG_STATUS), st);
      polls++;
    end
    if (st[1] !== 1'b1) begin
      $display("Timeout: the coprocessor in region 0x%04h never reported done.", region);
      stop_run();
    end else begin
      check_status("status at done", '{done: 1'b1, busy: 1'b0}, soc_pkg::status_t'(st[1:0]));
    end
  endtask

  task automatic run_op(input logic [15:0] region, input logic [OPW-1:0] a,
                        input logic [OPW-1:0] b, output soc_pkg::word_t res);
    bus_write(reg_addr(region, soc_pkg::REG_OP_A), 32'(a), 4'hF);
    bus_write(reg_addr(region, soc_pkg::REG_OP_B), 32'(b), 4'hF);
    bus_write(reg_addr(region, soc_pkg::REG_START), 32'd1, 4'hF);
    wait_done(region);
    bus_read(reg_addr(region, soc_pkg::REG_RESULT), res);
  endtask

  task automatic test_reset();
    logic [15:0]    regions [3] = '{soc_pkg::REGION_SQRT, soc_pkg::REGION_MULT,
                                    soc_pkg::REGION_DIV};
    soc_pkg::word_t got;
    test_name = "reset";
    check_word("rdata after reset", '0, rdata);
    for (int i = 0; i < 3; i++) begin
      bus_read(reg_addr(regions[i], soc_pkg::REG_STATUS), got);
      check_status("status after reset", '0, soc_pkg::status_t'(got[1:0]));
      check_word("status word after reset", '0, got);  // upper bits zero too
      bus_read(reg_addr(regions[i], soc_pkg::REG_RESULT), got);
      check_word("result after reset", '0, got);
    end
  endtask

  task automatic test_ram();
    logic [31:0]    r;
    logic [7:0]     idx;
    logic [3:0]     mask;
    soc_pkg::word_t base;
    soc_pkg::word_t upd;
    soc_pkg::word_t exp;
    soc_pkg::word_t got;
    test_name = "ram";
    for (int n = 0; n < 8; n++) begin
      rand_bits(8, r);
      idx = r[7:0];
      rand_bits(32, base);
      rand_bits(32, upd);
      rand_bits(4, r);
      mask = r[3:0];
      bus_write(32'h0050_0000 | {22'd0, idx, 2'b00}, base, 4'hF);  // aliased region
      bus_write(32'h0050_0000 | {22'd0, idx, 2'b00}, upd, mask);
      for (int lane = 0; lane < 4; lane++) begin
        exp[lane*8 +: 8] = mask[lane] ? upd[lane*8 +: 8] : base[lane*8 +: 8];
      end
      bus_read({22'd0, idx, 2'b00}, got);
      check_word("merged word", exp, got);
    end
    // unused region 0x0044 also lands in ram
    bus_write(32'h0044_0108, 32'hC3C3_0003, 4'hF);
    bus_read(32'h0000_0108, got);
    check_word("region 0x0044 fallback", 32'hC3C3_0003, got);
    // read latency
    bus_write(32'h0000_0100, 32'hA5A5_0001, 4'hF);
    bus_write(32'h0000_0104, 32'h5A5A_0002, 4'hF);
    bus_read(32'h0000_0100, got);
    check_word("first word", 32'hA5A5_0001, got);
    bus_read(32'h0000_0104, got);
    check_word("rdata during strobe cycle", 32'hA5A5_0001, rd_held);
    check_word("rdata one cycle after strobe", 32'h5A5A_0002, got);
  endtask

  task automatic test_mult();
    logic [31:0]    r;
    logic [OPW-1:0] a;
    logic [OPW-1:0] b;
    soc_pkg::word_t got;
    test_name = "mult";
    for (int n = 0; n < 22; n++) begin
      rand_bits(OPW, r);
      a = r[OPW-1:0];
      rand_bits(OPW, r);
      b = r[OPW-1:0];
      if (n == 20) begin
        a = '0;  // zero operand
      end else if (n == 21) begin
        a = '1;  // largest product
        b = '1;
      end
      run_op(soc_pkg::REGION_MULT, a, b, got);
      check_word("product", exp_product(a, b), got);
    end
  endtask

  task automatic test_div();
    logic [31:0]    r;
    logic [OPW-1:0] a;
    logic [OPW-1:0] b;
    soc_pkg::word_t got;
    test_name = "div";
    for (int n = 0; n < 20; n++) begin
      rand_bits(OPW, r);
      a = r[OPW-1:0];
      rand_bits((n < 10) ? OPW : 4, r);  // small divisors give big quotients
      b = r[OPW-1:0];
      if (n >= 18) begin
        b = '0;  // divide by zero
      end
      run_op(soc_pkg::REGION_DIV, a, b, got);
      check_word("quotient and remainder", exp_quot_rem(a, b), got);
    end
  endtask

  task automatic test_sqrt();
    int             roots [7] = '{0, 1, 2, 3, 15, 100, 255};
    logic [31:0]    r;
    logic [OPW-1:0] a;
    soc_pkg::word_t got;
    test_name = "sqrt";
    for (int n = 0; n < 20; n++) begin
      rand_bits(OPW, r);
      a = r[OPW-1:0];
      if (n < 7) begin
        a = OPW'(roots[n] * roots[n]);  // perfect squares
      end else if (n == 7) begin
        a = '1;
      end
      run_op(soc_pkg::REGION_SQRT, a, '0, got);
      check_word("root and remainder", exp_root(a), got);
    end
  endtask

  task automatic test_busy_start();
    logic [31:0]    r;
    logic [OPW-1:0] a1;
    logic [OPW-1:0] b1;
    logic [OPW-1:0] a2;
    logic [OPW-1:0] b2;
    soc_pkg::word_t got;
    test_name = "start while busy";
    rand_bits(OPW, r);
    a1 = r[OPW-1:0];
    rand_bits(OPW, r);
    b1 = r[OPW-1:0];
    rand_bits(OPW, r);
    a2 = r[OPW-1:0];
    rand_bits(OPW, r);
    b2 = r[OPW-1:0];
    bus_write(reg_addr(soc_pkg::REGION_MULT, soc_pkg::REG_OP_A), 32'(a1), 4'hF);
    bus_write(reg_addr(soc_pkg::REGION_MULT, soc_pkg::REG_OP_B), 32'(b1), 4'hF);
    bus_write(reg_addr(soc_pkg::REGION_MULT, soc_pkg::REG_START), 32'd1, 4'hF);
    bus_write(reg_addr(soc_pkg::REGION_MULT, soc_pkg::REG_OP_A), 32'(a2), 4'hF);
    bus_write(reg_addr(soc_pkg::REGION_MULT, soc_pkg::REG_OP_B), 32'(b2), 4'hF);
    bus_write(reg_addr(soc_pkg::REGION_MULT, soc_pkg::REG_START), 32'd1, 4'hF);  // dropped
    bus_read(reg_addr(soc_pkg::REGION_MULT, soc_pkg::REG_STATUS), got);
    check_status("busy after ignored start", '{done: 1'b0, busy: 1'b1},
                 soc_pkg::status_t'(got[1:0]));
    wait_done(soc_pkg::REGION_MULT);
    bus_read(reg_addr(soc_pkg::REGION_MULT, soc_pkg::REG_RESULT), got);
    check_word("first product kept", exp_product(a1, b1), got);
    bus_write(reg_addr(soc_pkg::REGION_MULT, soc_pkg::REG_START), 32'd1, 4'hF);
    wait_done(soc_pkg::REGION_MULT);
    bus_read(reg_addr(soc_pkg::REGION_MULT, soc_pkg::REG_RESULT), got);
    check_word("second product", exp_product(a2, b2), got);
  endtask

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    req        = '0;
    rd_held    = '0;
    lfsr_state = 32'h2259_dee3;
    test_name  = "setup";
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;  // release after 2 cycles
    @(posedge clk);
    test_reset();
    test_ram();
    test_mult();
    test_div();
    test_sqrt();
    test_busy_start();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
rtl/soc_pkg.sv
rtl/bus_decoder.sv
rtl/bram.sv
rtl/periph_mult.sv
rtl/periph_div.sv
rtl/periph_sqrt.sv
rtl/periph_soc.sv
verif/tb_periph_soc.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_periph_soc
FILELIST  ?= project.f
LOG       ?= sim.log
FAIL_MSG  := Checks failed
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
